//--- hdl/fp_misc_config.svh
// --------------------------------------------------
// Configuration macros for the FP misc unit
// Word widths, tag width and operation codes
// --------------------------------------------------
`ifndef FP_MISC_CONFIG_SVH
`define FP_MISC_CONFIG_SVH

// Single-precision word layout
`define FLEN    32      // FP word width, also result width
`define EXP_W   8       // Exponent field
`define FRAC_W  23      // Fraction field, hidden bit not stored

// Request tag carried alongside each operation
`define ID_W    3

// Operation select
`define FP_OP_W 2

`define FP_OP_CLASS  2'd0   // FCLASS.S
`define FP_OP_SGNJ   2'd1   // FSGNJ.S, copy rs2 sign
`define FP_OP_SGNJN  2'd2   // FSGNJN.S, inverted rs2 sign
`define FP_OP_SGNJX  2'd3   // FSGNJX.S, XOR of both signs

`endif

//--- hdl/fp_misc_pkg.sv
// --------------------------------------------------
// Shared types for the FP misc unit
// Floating-point word seen as raw bits or as fields
// --------------------------------------------------
`default_nettype none

`include "fp_misc_config.svh"

package fp_misc_pkg;

    // IEEE 754 single-precision field split
    typedef struct packed {
        logic              sign;   // Sign bit, MSB
        logic [`EXP_W-1:0] exp;    // Biased exponent
        logic [`FRAC_W-1:0] frac;  // Stored fraction
    } fp_fields_t;

    // One FP register word
    // bits is used when the word moves as a whole
    // f is used where sign, exponent or fraction are decoded
    typedef union packed {
        logic [`FLEN-1:0] bits;  // Raw word
        fp_fields_t       f;     // Field view
    } fp_word_u;

endpackage

`default_nettype wire

//--- hdl/fp_operand_unpack.sv
// --------------------------------------------------
// Operand decoder for the FP misc unit
// Derives hidden bit and special-case flags from rs1
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fp_misc_config.svh"

module fp_operand_unpack (
    input  fp_misc_pkg::fp_word_u rs1,               // Operand to decode
    output logic                  rs1_hidden_bit,    // Implicit leading one
    output logic [3:0]            rs1_special_case   // {inf, snan, qnan, zero}
);

    logic exp_zero;     // Exponent all zeros
    logic exp_ones;     // Exponent all ones
    logic frac_zero;    // Fraction all zeros
    logic frac_msb;     // Quiet bit position for NaNs
    logic is_inf;
    logic is_nan;
    logic is_snan;
    logic is_qnan;
    logic is_zero;

    // Field tests
    assign exp_zero  = (rs1.f.exp == {`EXP_W{1'b0}});
    assign exp_ones  = (rs1.f.exp == {`EXP_W{1'b1}});
    assign frac_zero = (rs1.f.frac == {`FRAC_W{1'b0}});
    assign frac_msb  = rs1.f.frac[`FRAC_W-1];

    // Normal numbers, infinities and NaNs all carry a nonzero exponent
    assign rs1_hidden_bit = ~exp_zero;

    // Max exponent splits into infinity and NaN on the fraction
    assign is_inf = exp_ones & frac_zero;
    assign is_nan = exp_ones & ~frac_zero;

    // RISC-V NaN convention, fraction MSB set means quiet
    assign is_snan = is_nan & ~frac_msb;
    assign is_qnan = is_nan & frac_msb;

    // Signed zero, sign handled downstream
    assign is_zero = exp_zero & frac_zero;

    // Flag order matches the core's precomputed special-case vector
    assign rs1_special_case = {
        is_inf,     // [3]
        is_snan,    // [2]
        is_qnan,    // [1]
        is_zero     // [0]
    };

endmodule

`default_nettype wire

//--- hdl/fp_class.sv
// --------------------------------------------------
// FCLASS.S pipeline
// Two advance-gated stages producing a one-hot mask
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fp_misc_config.svh"

module fp_class (
    input  logic                  clk,
    input  logic                  advance,           // Global pipeline enable
    input  fp_misc_pkg::fp_word_u rs1,               // Only the sign is taken here
    input  logic                  rs1_hidden_bit,    // From the operand decoder
    input  logic [3:0]            rs1_special_case,  // {inf, snan, qnan, zero}
    output logic [9:0]            class_mask         // One-hot class, bit 0 is -inf
);

    // Stage one
    logic       sign_r;
    logic       hidden_r;
    logic [3:0] special_r;

    // Stage two
    logic       sign_rr;
    logic       hidden_rr;
    logic [3:0] special_rr;

    // Decoded flags from stage two
    logic is_inf;
    logic is_snan;
    logic is_qnan;
    logic is_zero;
    logic is_subnormal;
    logic is_normal;

    // Class terms
    logic neg_inf;
    logic neg_normal;
    logic neg_subnormal;
    logic neg_zero;
    logic pos_zero;
    logic pos_subnormal;
    logic pos_normal;
    logic pos_inf;

    // Pipeline registers, no reset on data
    always_ff @(posedge clk) begin
        if (advance) begin
            sign_r     <= rs1.f.sign;
            hidden_r   <= rs1_hidden_bit;
            special_r  <= rs1_special_case;
            sign_rr    <= sign_r;
            hidden_rr  <= hidden_r;
            special_rr <= special_r;
        end
    end

    assign is_inf  = special_rr[3];
    assign is_snan = special_rr[2];
    assign is_qnan = special_rr[1];
    assign is_zero = special_rr[0];

    // Zero also lacks the hidden bit, so it is excluded here
    assign is_subnormal = ~hidden_rr & ~is_zero;
    // Max exponent sets the hidden bit too
    assign is_normal    = hidden_rr & ~is_inf & ~is_snan & ~is_qnan;

    assign neg_inf       =  sign_rr & is_inf;
    assign neg_normal    =  sign_rr & is_normal;
    assign neg_subnormal =  sign_rr & is_subnormal;
    assign neg_zero      =  sign_rr & is_zero;
    assign pos_zero      = ~sign_rr & is_zero;
    assign pos_subnormal = ~sign_rr & is_subnormal;
    assign pos_normal    = ~sign_rr & is_normal;
    assign pos_inf       = ~sign_rr & is_inf;

    // NaN classes ignore the sign
    assign class_mask = {is_qnan, is_snan, pos_inf, pos_normal, pos_subnormal,
                         pos_zero, neg_zero, neg_subnormal, neg_normal, neg_inf};

endmodule

`default_nettype wire

//--- hdl/fp_sign_inject.sv
// --------------------------------------------------
// FSGNJ.S / FSGNJN.S / FSGNJX.S pipeline
// New sign from rs2, magnitude from rs1, two stages
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fp_misc_config.svh"

module fp_sign_inject (
    input  logic                  clk,
    input  logic                  advance,      // Global pipeline enable
    input  logic [`FP_OP_W-1:0]   op,           // Selects the sign rule
    input  fp_misc_pkg::fp_word_u rs1,          // Exponent and fraction source
    input  fp_misc_pkg::fp_word_u rs2,          // Sign source
    output fp_misc_pkg::fp_word_u inject_word   // Result word
);

    logic new_sign;     // Stage one sign, combinational

    // Stage one
    logic               sign_r;
    logic [`EXP_W-1:0]  exp_r;
    logic [`FRAC_W-1:0] frac_r;

    // Stage two, delay only
    logic               sign_rr;
    logic [`EXP_W-1:0]  exp_rr;
    logic [`FRAC_W-1:0] frac_rr;

    // Sign rule
    always_comb begin
        case (op)
            `FP_OP_SGNJ:  new_sign = rs2.f.sign;
            `FP_OP_SGNJN: new_sign = ~rs2.f.sign;
            `FP_OP_SGNJX: new_sign = rs1.f.sign ^ rs2.f.sign;
            default:      new_sign = rs1.f.sign;   // CLASS, result unused
        endcase
    end

    // Magnitude is passed through untouched, NaN payloads included
    always_ff @(posedge clk) begin
        if (advance) begin
            sign_r  <= new_sign;
            exp_r   <= rs1.f.exp;
            frac_r  <= rs1.f.frac;
            sign_rr <= sign_r;   // Matches classifier latency
            exp_rr  <= exp_r;
            frac_rr <= frac_r;
        end
    end

    // Rebuild the word from its fields
    always_comb begin
        inject_word.f.sign = sign_rr;
        inject_word.f.exp  = exp_rr;
        inject_word.f.frac = frac_rr;
    end

endmodule

`default_nettype wire

//--- hdl/fp_result_select.sv
// --------------------------------------------------
// Result stage of the FP misc unit
// Tag pipelines and writeback word selection
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fp_misc_config.svh"

module fp_result_select (
    input  logic                  clk,
    input  logic                  rst_n,        // Synchronous, active low
    input  logic                  advance,      // Global pipeline enable
    input  logic                  new_request,  // Valid only with advance high
    input  logic [`ID_W-1:0]      id,
    input  logic [`FP_OP_W-1:0]   op,
    input  logic [9:0]            class_mask,   // From the classifier
    input  fp_misc_pkg::fp_word_u inject_word,  // From the sign injector
    output logic                  wb_done,
    output logic [`ID_W-1:0]      wb_id,
    output fp_misc_pkg::fp_word_u wb_rd
);

    logic                done_r;
    logic                done_rr;
    logic [`ID_W-1:0]    id_r;
    logic [`ID_W-1:0]    id_rr;
    logic [`FP_OP_W-1:0] op_r;
    logic [`FP_OP_W-1:0] op_rr;

    // Done bits are the only control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_r  <= 1'b0;
            done_rr <= 1'b0;
        end else if (advance) begin
            done_r  <= new_request;  // Bubble enters as zero
            done_rr <= done_r;
        end
    end

    // Tags follow the data pipelines
    always_ff @(posedge clk) begin
        if (advance) begin
            id_r  <= id;
            id_rr <= id_r;
            op_r  <= op;
            op_rr <= op_r;
        end
    end

    // Both units always compute, op picks the live one
    always_comb begin
        if (op_rr == `FP_OP_CLASS) begin
            wb_rd.bits = {{(`FLEN-10){1'b0}}, class_mask};  // Zero-extended mask
        end else begin
            wb_rd = inject_word;
        end
    end

    assign wb_done = done_rr;
    assign wb_id   = id_rr;

endmodule

`default_nettype wire

//--- hdl/fp_misc_unit.sv
// --------------------------------------------------
// Miscellaneous single-precision FP unit
// FCLASS.S and FSGNJ variants, two-stage pipeline
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fp_misc_config.svh"

module fp_misc_unit (
    input  logic                  clk,
    input  logic                  rst_n,        // Synchronous, active low
    input  logic                  advance,      // Moves every pipeline register
    input  logic                  new_request,  // Issue strobe
    input  logic [`ID_W-1:0]      id,           // Request tag
    input  logic [`FP_OP_W-1:0]   op,           // CLASS, SGNJ, SGNJN or SGNJX
    input  fp_misc_pkg::fp_word_u rs1,
    input  fp_misc_pkg::fp_word_u rs2,
    output logic                  wb_done,      // Result valid pulse
    output logic [`ID_W-1:0]      wb_id,
    output fp_misc_pkg::fp_word_u wb_rd
);

    logic                  rs1_hidden_bit;
    logic [3:0]            rs1_special_case;
    logic [9:0]            class_mask;
    fp_misc_pkg::fp_word_u inject_word;

    // Precomputed operand flags, as the core supplies them
    fp_operand_unpack u_operand_unpack (
        .rs1              (rs1),
        .rs1_hidden_bit   (rs1_hidden_bit),
        .rs1_special_case (rs1_special_case)
    );

    fp_class u_class (
        .clk              (clk),
        .advance          (advance),
        .rs1              (rs1),
        .rs1_hidden_bit   (rs1_hidden_bit),
        .rs1_special_case (rs1_special_case),
        .class_mask       (class_mask)
    );

    // Runs on every request, result dropped for CLASS
    fp_sign_inject u_sign_inject (
        .clk         (clk),
        .advance     (advance),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .inject_word (inject_word)
    );

    fp_result_select u_result_select (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .new_request (new_request),
        .id          (id),
        .op          (op),
        .class_mask  (class_mask),
        .inject_word (inject_word),
        .wb_done     (wb_done),
        .wb_id       (wb_id),
        .wb_rd       (wb_rd)
    );

endmodule

`default_nettype wire

//--- test/fp_misc_unit_tb.sv
// --------------------------------------------------
// Testbench for the FP misc unit
// Pattern-driven with random stalls and bubbles
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "fp_misc_config.svh"

module fp_misc_unit_tb;

    localparam int RESET_CYCLES  = 5;
    localparam int IDLE_CYCLES   = 8;     // Idle cycles with advance high
    localparam int ISSUE_TIMEOUT = 64;    // Cycles allowed to place one request
    localparam int DRAIN_TIMEOUT = 200;

    logic                  clk;
    logic                  rst_n;
    logic                  advance;
    logic                  new_request;
    logic [`ID_W-1:0]      id;
    logic [`FP_OP_W-1:0]   op;
    fp_misc_pkg::fp_word_u rs1;
    fp_misc_pkg::fp_word_u rs2;
    logic                  wb_done;
    logic [`ID_W-1:0]      wb_id;
    fp_misc_pkg::fp_word_u wb_rd;

    // Vectors as read from the data file
    logic [`FP_OP_W-1:0]   pat_op[$];
    fp_misc_pkg::fp_word_u pat_rs1[$];
    fp_misc_pkg::fp_word_u pat_rs2[$];
    fp_misc_pkg::fp_word_u pat_rd[$];

    // Issued requests waiting for writeback in issue order
    logic [`ID_W-1:0]      exp_id_q[$];
    fp_misc_pkg::fp_word_u exp_rd_q[$];

    logic [`ID_W-1:0] next_id;        // Wraps like the core's tag counter

    fp_misc_unit u_fp_misc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .new_request (new_request),
        .id          (id),
        .op          (op),
        .rs1         (rs1),
        .rs2         (rs2),
        .wb_done     (wb_done),
        .wb_id       (wb_id),
        .wb_rd       (wb_rd)
    );

    always #5 clk = ~clk;   // 10 ns period

    task automatic abort_run(input string why);
        $display("*** TEST FAILED ***");
        $fatal(1, "%s", why);
    endtask

    task automatic check_rd(input fp_misc_pkg::fp_word_u expected,
                            input fp_misc_pkg::fp_word_u got);
        if (got !== expected) begin
            $display("** Error at %0t: wb_rd is %h, expected %h", $time, got.bits, expected.bits);
            $display("*** TEST FAILED ***");
            $fatal(1, "wb_rd mismatch");
        end
    endtask

    task automatic check_id(input logic [`ID_W-1:0] expected, input logic [`ID_W-1:0] got);
        if (got !== expected) begin
            $display("** Error at %0t: wb_id is %0d, expected %0d", $time, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "wb_id mismatch");
        end
    endtask

    task automatic load_patterns;
        int                    fd;
        int                    n;
        string                 line;
        logic [`FP_OP_W-1:0]   f_op;
        fp_misc_pkg::fp_word_u f_rs1;
        fp_misc_pkg::fp_word_u f_rs2;
        fp_misc_pkg::fp_word_u f_rd;
        fd = $fopen("test/fp_misc_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open test/fp_misc_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != 8'h23) begin            // Skip # lines
                    n = $sscanf(line, "%h %h %h %h", f_op, f_rs1.bits, f_rs2.bits, f_rd.bits);
                    if (n == 4) begin
                        pat_op.push_back(f_op);
                        pat_rs1.push_back(f_rs1);
                        pat_rs2.push_back(f_rs2);
                        pat_rd.push_back(f_rd);
                    end
                end
            end
            $fclose(fd);
        end
        if (pat_op.size() == 0) begin
            abort_run("The pattern file holds no vectors");
        end
    endtask

    // Places one vector and retries through stalls and bubbles
    task automatic issue_pattern(input int idx);
        int          tries;
        logic        issued;
        logic [31:0] rnd;
        tries  = 0;
        issued = 1'b0;
        while (!issued) begin
            if (tries == ISSUE_TIMEOUT) begin
                abort_run("No advancing cycle came up to issue a request");
            end
            @(negedge clk);
            tries = tries + 1;
            rnd     = $urandom;
            advance = (rnd[1:0] != 2'b00);                          // Low about 1 in 4
            if (!advance || rnd[4:2] == 3'd0) begin
                new_request = ~advance & rnd[5];                    // Ignored while stalled
                op          = rnd[7:6];
                id          = rnd[10:8];
                rs1.bits    = $urandom;                             // Junk must not leak out
                rs2.bits    = $urandom;
            end else begin
                new_request = 1'b1;
                id          = next_id;
                op          = pat_op[idx];
                rs1         = pat_rs1[idx];
                rs2         = pat_rs2[idx];
                exp_id_q.push_back(next_id);
                exp_rd_q.push_back(pat_rd[idx]);
                next_id = next_id + 1'b1;
                issued  = 1'b1;
            end
        end
    endtask

    // Oldest request compared whenever wb_done is high and retired on advancing edges
    always @(posedge clk) begin
        if (rst_n && wb_done) begin
            if (exp_id_q.size() == 0) begin
                abort_run("wb_done went high with no request outstanding");
            end else begin
                check_id(exp_id_q[0], wb_id);
                check_rd(exp_rd_q[0], wb_rd);
                if (advance) begin
                    void'(exp_id_q.pop_front());
                    void'(exp_rd_q.pop_front());
                end
            end
        end
    end

    initial begin
        int          idx;
        int          cycles;
        logic [31:0] rnd;
        clk          = 1'b0;
        rst_n        = 1'b0;
        advance      = 1'b0;
        new_request  = 1'b0;
        id           = '0;
        op           = `FP_OP_CLASS;
        rs1.bits     = '0;
        rs2.bits     = '0;
        next_id      = '0;
        void'($urandom(32'hc2ee_577a));
        load_patterns();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Empty pipeline with advance high
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            advance     = 1'b1;
            new_request = 1'b0;
        end

        for (idx = 0; idx < pat_op.size(); idx = idx + 1) begin
            issue_pattern(idx);
        end

        // Drain with stalls still active
        cycles = 0;
        while (exp_id_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
            @(negedge clk);
            rnd         = $urandom;
            advance     = (rnd[1:0] != 2'b00);
            new_request = 1'b0;
            cycles      = cycles + 1;
        end
        repeat (4) begin
            @(negedge clk);
            advance     = 1'b1;
            new_request = 1'b0;
        end

        if (exp_id_q.size() != 0) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Drain timed out with %0d results still outstanding", exp_id_q.size());
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- fp_misc_unit.f
+incdir+hdl
hdl/fp_misc_pkg.sv
hdl/fp_operand_unpack.sv
hdl/fp_class.sv
hdl/fp_sign_inject.sv
hdl/fp_result_select.sv
hdl/fp_misc_unit.sv
test/fp_misc_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FP misc unit testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps \
    -f fp_misc_unit.f \
    --top-module fp_misc_unit_tb \
    -o fp_misc_unit_sim \
    && ./obj_dir/fp_misc_unit_sim \
    || { echo "Simulation failed"; exit 1; }

echo "Simulation finished cleanly"

//--- test/fp_misc_patterns.txt
# Columns: op rs1 rs2 expected_rd, all hex
# op 0 FCLASS.S, 1 FSGNJ.S, 2 FSGNJN.S, 3 FSGNJX.S
0 ff800000 00000000 00000001
0 c0490fdb 00000000 00000002
0 80000001 00000000 00000004
0 80000000 00000000 00000008
0 00000000 00000000 00000010
0 00000001 00000000 00000020
0 3f800000 00000000 00000040
0 7f800000 00000000 00000080
0 7f800001 00000000 00000100
0 7fc00000 00000000 00000200
0 ffc00000 3f800000 00000200
0 ff800001 00000000 00000100
0 007fffff 00000000 00000020
0 807fffff 00000000 00000004
0 7f7fffff 00000000 00000040
0 00800000 00000000 00000040
0 7fbfffff 00000000 00000100
0 80800000 00000000 00000002
1 3f800000 c0000000 bf800000
1 bf800000 40000000 3f800000
1 7fc00000 80000000 ffc00000
1 00000000 ff800000 80000000
1 ff800000 7fc00000 7f800000
2 3f800000 c0000000 3f800000
2 3f800000 40000000 bf800000
2 80000000 00000000 80000000
2 7f800001 ffc00000 7f800001
2 c0490fdb 3f800000 c0490fdb
3 3f800000 c0000000 bf800000
3 bf800000 c0000000 3f800000
3 bf800000 40000000 bf800000
3 ffc00000 80000000 7fc00000
3 00000001 80000000 80000001
3 80000000 80000000 00000000
